/* Bender.yml */
package:
  name: noc_tile_link

sources:
  - include_dirs:
      - design
    files:
      - design/noc_msg_pkg.sv
      - design/noc_flit_pkg.sv
      - design/noc_pkt_source.sv
      - design/noc_link_fifo.sv
      - design/noc_pkt_sink.sv
      - design/noc_tile_link.sv

  - target: test
    include_dirs:
      - design
    files:
      - test/noc_tile_link_tb.sv

/* design/noc_consts.svh */
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Width of one flit on the tile link.
`define NOC_FLIT_WIDTH 32

// Entries in the link FIFO between the two tiles.
`define NOC_FIFO_DEPTH 4

// Most flits in one packet, the header flit included.
`define NOC_MAX_PKT_LEN 31

// Header field widths. Together they fill one flit.
`define NOC_ID_WIDTH 4
`define NOC_CLASS_WIDTH 3
`define NOC_LEN_WIDTH 5
`define NOC_TAG_WIDTH 16

`endif

/* design/noc_flit_pkg.sv */
`default_nettype none

`include "noc_consts.svh"

package noc_flit_pkg;

  import noc_msg_pkg::*;

  // First flit of every packet. Fields are listed from the MSB down.
  typedef struct packed {
    tile_id_t                  dst;
    tile_id_t                  src;
    msg_class_e                cls;
    logic [`NOC_LEN_WIDTH-1:0] len;  // Flits in the packet, header included.
    logic [`NOC_TAG_WIDTH-1:0] tag;
  } noc_hdr_t;

  // One link word, seen as a header on the first flit and as raw data after it.
  typedef union packed {
    noc_hdr_t                   hdr;
    logic [`NOC_FLIT_WIDTH-1:0] data;
  } noc_flit_u;

endpackage

`default_nettype wire

/* design/noc_link_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_consts.svh"

module noc_link_fifo #(
  parameter int DEPTH = `NOC_FIFO_DEPTH
) (
  input  logic                    clk,
  input  logic                    arst_n_i,

  input  noc_flit_pkg::noc_flit_u in_flit_i,
  input  logic                    in_last_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,

  output noc_flit_pkg::noc_flit_u out_flit_o,
  output logic                    out_last_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i
);

  import noc_flit_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  noc_flit_u        flit_mem [DEPTH];
  logic             last_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             do_wr;
  logic             do_rd;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full        = (count_q == CNT_W'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign in_ready_o  = !full || out_ready_i;  // A full FIFO still takes a flit on a pop.
  assign do_wr       = in_valid_i && in_ready_o;
  assign do_rd       = out_valid_o && out_ready_i;

  assign out_flit_o = flit_mem[rd_ptr_q];
  assign out_last_o = last_mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      flit_mem[wr_ptr_q] <= in_flit_i;
      last_mem[wr_ptr_q] <= in_last_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_rd) rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Push and pop together keep the level.
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/noc_msg_pkg.sv */
`default_nettype none

`include "noc_consts.svh"

package noc_msg_pkg;

  // Address of a tile in the mesh.
  typedef logic [`NOC_ID_WIDTH-1:0] tile_id_t;

  // Traffic class carried in the packet header.
  typedef enum logic [`NOC_CLASS_WIDTH-1:0] {
    DMA  = 3'd0,
    MPB  = 3'd1,
    SYNC = 3'd2,
    CTRL = 3'd3
  } msg_class_e;

endpackage

`default_nettype wire

/* design/noc_pkt_sink.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_consts.svh"

module noc_pkt_sink #(
  parameter noc_msg_pkg::tile_id_t LOCAL_ID = '0
) (
  input  logic                       clk,
  input  logic                       arst_n_i,

  input  noc_flit_pkg::noc_flit_u    in_flit_i,
  input  logic                       in_last_i,
  input  logic                       in_valid_i,
  output logic                       in_ready_o,

  input  logic                       rx_stall_i,
  output logic                       rx_valid_o,
  output logic                       rx_drop_o,
  output noc_msg_pkg::tile_id_t      rx_src_o,
  output noc_msg_pkg::msg_class_e    rx_class_o,
  output logic [`NOC_LEN_WIDTH-1:0]  rx_len_o,
  output logic [`NOC_TAG_WIDTH-1:0]  rx_tag_o,
  output logic [`NOC_FLIT_WIDTH-1:0] rx_sum_o
);

  localparam logic [`NOC_LEN_WIDTH-1:0] MAX_LEN = `NOC_MAX_PKT_LEN;

  logic in_body_q;  // Set once the header of the current packet is taken.
  logic match_q;
  logic take;
  logic pkt_match;

  assign in_ready_o = !rx_stall_i;
  assign take       = in_valid_i && in_ready_o;

  // On the header flit the match is decoded live, later it comes from the register.
  assign pkt_match = in_body_q ? match_q : (in_flit_i.hdr.dst == LOCAL_ID);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_body_q  <= 1'b0;
      rx_valid_o <= 1'b0;
      rx_drop_o  <= 1'b0;
    end else begin
      rx_valid_o <= take && in_last_i && pkt_match;
      rx_drop_o  <= take && in_last_i && !pkt_match;
      if (take) begin
        in_body_q <= !in_last_i;
      end
    end
  end

  // The report fields are the capture registers themselves. They are
  // complete on the edge that takes the last flit, which also raises the strobe.
  always_ff @(posedge clk) begin
    if (take) begin
      if (!in_body_q) begin
        match_q    <= (in_flit_i.hdr.dst == LOCAL_ID);
        rx_src_o   <= in_flit_i.hdr.src;
        rx_class_o <= in_flit_i.hdr.cls;
        rx_tag_o   <= in_flit_i.hdr.tag;
        rx_len_o   <= 'd1;
        rx_sum_o   <= '0;
      end else begin
        rx_sum_o <= rx_sum_o ^ in_flit_i.data;
        if (rx_len_o != MAX_LEN) begin
          rx_len_o <= rx_len_o + 1'b1;  // Saturates on an overlong packet.
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/noc_pkt_source.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_consts.svh"

module noc_pkt_source #(
  parameter noc_msg_pkg::tile_id_t SRC_ID = '0
) (
  input  logic                       clk,
  input  logic                       arst_n_i,

  input  logic                       tx_req_i,
  input  noc_msg_pkg::tile_id_t      tx_dst_i,
  input  noc_msg_pkg::msg_class_e    tx_class_i,
  input  logic [`NOC_LEN_WIDTH-1:0]  tx_len_i,
  input  logic [`NOC_TAG_WIDTH-1:0]  tx_tag_i,
  input  logic [`NOC_FLIT_WIDTH-1:0] tx_seed_i,
  output logic                       tx_busy_o,

  output noc_flit_pkg::noc_flit_u    out_flit_o,
  output logic                       out_last_o,
  output logic                       out_valid_o,
  input  logic                       out_ready_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HDR,
    ST_PAY
  } state_t;

  state_t                     state_q;
  logic [`NOC_LEN_WIDTH-1:0]  pay_left_q;  // Payload flits not yet accepted.
  logic [`NOC_FLIT_WIDTH-1:0] seed_q;
  logic                       start;
  logic                       flit_done;

  assign start     = (state_q == ST_IDLE) && tx_req_i;  // Strobes while busy are dropped.
  assign flit_done = out_valid_o && out_ready_i;

  assign tx_busy_o   = (state_q != ST_IDLE);
  assign out_valid_o = (state_q != ST_IDLE);

  // A header-only packet ends on the header itself.
  assign out_last_o = ((state_q == ST_HDR) && (pay_left_q == '0)) ||
                      ((state_q == ST_PAY) && (pay_left_q == 'd1));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= ST_IDLE;
      pay_left_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            state_q    <= ST_HDR;
            pay_left_q <= tx_len_i - 1'b1;
          end
        end
        ST_HDR: begin
          if (flit_done) begin
            state_q <= (pay_left_q == '0) ? ST_IDLE : ST_PAY;
          end
        end
        ST_PAY: begin
          if (flit_done) begin
            pay_left_q <= pay_left_q - 1'b1;
            if (pay_left_q == 'd1) begin
              state_q <= ST_IDLE;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // The output word is built in place. The header goes in through the
  // hdr view, then every accepted flit advances the data view by one.
  always_ff @(posedge clk) begin
    if (start) begin
      out_flit_o.hdr.dst <= tx_dst_i;
      out_flit_o.hdr.src <= SRC_ID;
      out_flit_o.hdr.cls <= tx_class_i;
      out_flit_o.hdr.len <= tx_len_i;
      out_flit_o.hdr.tag <= tx_tag_i;
      seed_q             <= tx_seed_i;
    end else if (flit_done) begin
      if (state_q == ST_HDR) begin
        out_flit_o.data <= seed_q;  // First payload flit is the seed.
      end else begin
        out_flit_o.data <= out_flit_o.data + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/noc_tile_link.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_consts.svh"

module noc_tile_link #(
  parameter noc_msg_pkg::tile_id_t SRC_ID = 4'd1,
  parameter noc_msg_pkg::tile_id_t DST_ID = 4'd2
) (
  input  logic                       clk,
  input  logic                       arst_n_i,

  input  logic                       tx_req_i,
  input  noc_msg_pkg::tile_id_t      tx_dst_i,
  input  noc_msg_pkg::msg_class_e    tx_class_i,
  input  logic [`NOC_LEN_WIDTH-1:0]  tx_len_i,
  input  logic [`NOC_TAG_WIDTH-1:0]  tx_tag_i,
  input  logic [`NOC_FLIT_WIDTH-1:0] tx_seed_i,
  output logic                       tx_busy_o,

  input  logic                       rx_stall_i,
  output logic                       rx_valid_o,
  output logic                       rx_drop_o,
  output noc_msg_pkg::tile_id_t      rx_src_o,
  output noc_msg_pkg::msg_class_e    rx_class_o,
  output logic [`NOC_LEN_WIDTH-1:0]  rx_len_o,
  output logic [`NOC_TAG_WIDTH-1:0]  rx_tag_o,
  output logic [`NOC_FLIT_WIDTH-1:0] rx_sum_o
);

  import noc_flit_pkg::*;

  // Flits from the source tile into the link FIFO.
  noc_flit_u src_flit;
  logic      src_last;
  logic      src_valid;
  logic      src_ready;

  // Flits from the link FIFO into the sink tile.
  noc_flit_u snk_flit;
  logic      snk_last;
  logic      snk_valid;
  logic      snk_ready;

  noc_pkt_source #(
    .SRC_ID (SRC_ID)
  ) u_source (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .tx_req_i    (tx_req_i),
    .tx_dst_i    (tx_dst_i),
    .tx_class_i  (tx_class_i),
    .tx_len_i    (tx_len_i),
    .tx_tag_i    (tx_tag_i),
    .tx_seed_i   (tx_seed_i),
    .tx_busy_o   (tx_busy_o),
    .out_flit_o  (src_flit),
    .out_last_o  (src_last),
    .out_valid_o (src_valid),
    .out_ready_i (src_ready)
  );

  noc_link_fifo #(
    .DEPTH (`NOC_FIFO_DEPTH)
  ) u_fifo (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .in_flit_i   (src_flit),
    .in_last_i   (src_last),
    .in_valid_i  (src_valid),
    .in_ready_o  (src_ready),
    .out_flit_o  (snk_flit),
    .out_last_o  (snk_last),
    .out_valid_o (snk_valid),
    .out_ready_i (snk_ready)
  );

  noc_pkt_sink #(
    .LOCAL_ID (DST_ID)
  ) u_sink (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .in_flit_i  (snk_flit),
    .in_last_i  (snk_last),
    .in_valid_i (snk_valid),
    .in_ready_o (snk_ready),
    .rx_stall_i (rx_stall_i),
    .rx_valid_o (rx_valid_o),
    .rx_drop_o  (rx_drop_o),
    .rx_src_o   (rx_src_o),
    .rx_class_o (rx_class_o),
    .rx_len_o   (rx_len_o),
    .rx_tag_o   (rx_tag_o),
    .rx_sum_o   (rx_sum_o)
  );

endmodule

`default_nettype wire

/* noc_tile_link.f */
+incdir+design
design/noc_msg_pkg.sv
design/noc_flit_pkg.sv
design/noc_pkt_source.sv
design/noc_link_fifo.sv
design/noc_pkt_sink.sv
design/noc_tile_link.sv
test/noc_tile_link_tb.sv

/* test/noc_tile_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_consts.svh"

module noc_tile_link_tb;

  import noc_msg_pkg::*;

  localparam tile_id_t SRC_ID       = 4'd1;
  localparam tile_id_t DST_ID       = 4'd2;
  localparam int       MAX_VECS     = 32;
  localparam int       RESET_CYCLES = 10;
  localparam int       DRAIN_CYCLES = 40;

  logic                       clk = 1'b0;
  logic                       arst_n_i;
  logic                       tx_req_i;
  tile_id_t                   tx_dst_i;
  msg_class_e                 tx_class_i;
  logic [`NOC_LEN_WIDTH-1:0]  tx_len_i;
  logic [`NOC_TAG_WIDTH-1:0]  tx_tag_i;
  logic [`NOC_FLIT_WIDTH-1:0] tx_seed_i;
  logic                       tx_busy_o;
  logic                       rx_stall_i;
  logic                       rx_valid_o;
  logic                       rx_drop_o;
  tile_id_t                   rx_src_o;
  msg_class_e                 rx_class_o;
  logic [`NOC_LEN_WIDTH-1:0]  rx_len_o;
  logic [`NOC_TAG_WIDTH-1:0]  rx_tag_o;
  logic [`NOC_FLIT_WIDTH-1:0] rx_sum_o;

  // One entry per vector line, in file column order.
  logic [31:0] v_num  [MAX_VECS];
  logic [31:0] v_dst  [MAX_VECS];
  logic [31:0] v_cls  [MAX_VECS];
  logic [31:0] v_len  [MAX_VECS];
  logic [31:0] v_tag  [MAX_VECS];
  logic [31:0] v_seed [MAX_VECS];
  logic [31:0] v_mask [MAX_VECS];
  logic [31:0] v_sum  [MAX_VECS];
  logic [31:0] v_drop [MAX_VECS];

  int          num_vecs     = 0;
  int          error_count  = 0;
  int          pass_tests   = 0;
  int          fail_tests   = 0;
  int          report_count = 0;
  int          cycle_count  = 0;
  int          limit_cycles = 0;  // Zero until the vectors are read.
  int unsigned rnd;

  noc_tile_link #(
    .SRC_ID (SRC_ID),
    .DST_ID (DST_ID)
  ) noc_tile_link_inst (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .tx_req_i   (tx_req_i),
    .tx_dst_i   (tx_dst_i),
    .tx_class_i (tx_class_i),
    .tx_len_i   (tx_len_i),
    .tx_tag_i   (tx_tag_i),
    .tx_seed_i  (tx_seed_i),
    .tx_busy_o  (tx_busy_o),
    .rx_stall_i (rx_stall_i),
    .rx_valid_o (rx_valid_o),
    .rx_drop_o  (rx_drop_o),
    .rx_src_o   (rx_src_o),
    .rx_class_o (rx_class_o),
    .rx_len_o   (rx_len_o),
    .rx_tag_o   (rx_tag_o),
    .rx_sum_o   (rx_sum_o)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (limit_cycles != 0 && cycle_count >= limit_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles.", limit_cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  // Every report strobe is counted, so an extra packet shows up at the end.
  always @(negedge clk) begin
    if (arst_n_i && (rx_valid_o || rx_drop_o)) report_count++;
  end

  function automatic logic [31:0] payload_xor(input logic [31:0] seed, input logic [31:0] len);
    logic [31:0] acc;
    int          k;
    acc = '0;
    for (k = 0; k < int'(len) - 1; k++) begin
      acc = acc ^ (seed + k);  // Payload flit k carries seed plus k.
    end
    return acc;
  endfunction

  task automatic flag_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("CHECK FAILED at %0t: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
    error_count++;
  endtask

  task automatic read_vectors();
    int fd;
    int n;
    int c;
    fd = $fopen("test/noc_tile_link_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file test/noc_tile_link_vectors.txt.");
      error_count++;
    end else begin
      while (!$feof(fd) && num_vecs < MAX_VECS) begin
        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                    v_num[num_vecs], v_dst[num_vecs], v_cls[num_vecs],
                    v_len[num_vecs], v_tag[num_vecs], v_seed[num_vecs],
                    v_mask[num_vecs], v_sum[num_vecs], v_drop[num_vecs]);
        if (n == 9) begin
          num_vecs++;
        end else begin
          c = $fgetc(fd);  // Comment line, skip to its end.
          while (c != "\n" && c != -1) c = $fgetc(fd);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_report(input int idx, input logic [31:0] exp_sum, input logic exp_drop);
    if (rx_valid_o && rx_drop_o) begin
      $display("Test %0d: rx_valid_o and rx_drop_o were high together.", v_num[idx]);
      error_count++;
    end
    if (rx_drop_o !== exp_drop) flag_mismatch("rx_drop_o", exp_drop, rx_drop_o);
    if (rx_valid_o !== !exp_drop) flag_mismatch("rx_valid_o", !exp_drop, rx_valid_o);
    if (!exp_drop) begin
      if (rx_src_o !== SRC_ID) flag_mismatch("rx_src_o", SRC_ID, rx_src_o);
      if (rx_class_o !== v_cls[idx][2:0]) flag_mismatch("rx_class_o", v_cls[idx], rx_class_o);
      if (rx_len_o !== v_len[idx][4:0]) flag_mismatch("rx_len_o", v_len[idx], rx_len_o);
      if (rx_tag_o !== v_tag[idx][15:0]) flag_mismatch("rx_tag_o", v_tag[idx], rx_tag_o);
      if (rx_sum_o !== exp_sum) flag_mismatch("rx_sum_o", exp_sum, rx_sum_o);
    end
  endtask

  task automatic run_test(input int idx);
    logic [31:0] exp_sum;
    logic        exp_drop;
    logic [15:0] mask;
    logic        seen;
    logic        all_stalled;
    int          errs_before;
    int          waited;
    int          k;
    errs_before = error_count;
    exp_sum     = payload_xor(v_seed[idx], v_len[idx]);
    exp_drop    = (v_dst[idx][3:0] != DST_ID);
    mask        = v_mask[idx][15:0];
    if (exp_sum !== v_sum[idx]) begin
      $display("Test %0d: the file's sum 0x%0h breaks the payload rule, which gives 0x%0h.",
               v_num[idx], v_sum[idx], exp_sum);
      error_count++;
    end
    if (exp_drop !== v_drop[idx][0]) begin
      $display("Test %0d: the file's drop flag does not match the destination.", v_num[idx]);
      error_count++;
    end
    rnd = $urandom % 4;
    repeat (rnd) @(negedge clk);
    while (tx_busy_o) @(negedge clk);
    tx_req_i   = 1'b1;
    tx_dst_i   = v_dst[idx][3:0];
    tx_class_i = msg_class_e'(v_cls[idx][2:0]);
    tx_len_i   = v_len[idx][4:0];
    tx_tag_i   = v_tag[idx][15:0];
    tx_seed_i  = v_seed[idx];
    rx_stall_i = mask[0];
    seen       = 1'b0;
    fork
      begin
        all_stalled = mask[0];
        for (k = 1; k <= 16; k++) begin
          @(negedge clk);
          // A sink stalled from the start cannot absorb more than the FIFO holds.
          if ((k == 1 || (all_stalled && v_len[idx] > `NOC_FIFO_DEPTH)) && tx_busy_o !== 1'b1)
            flag_mismatch("tx_busy_o", 1'b1, tx_busy_o);
          tx_req_i = (k == 1);  // Second strobe lands while busy.
          if (k == 1) tx_tag_i = ~tx_tag_i;
          rx_stall_i  = (k < 16) ? mask[k] : 1'b0;
          all_stalled = all_stalled && rx_stall_i;
        end
      end
      begin
        waited = 0;
        while (!seen && waited < int'(v_len[idx]) + 24) begin
          @(negedge clk);
          waited++;
          if (rx_valid_o || rx_drop_o) begin
            seen = 1'b1;
            check_report(idx, exp_sum, exp_drop);
          end
        end
      end
    join
    if (!seen) begin
      $display("Test %0d: no report arrived after the command.", v_num[idx]);
      error_count++;
    end
    if (error_count == errs_before) begin
      pass_tests++;
      $display("Test %0d: passed", v_num[idx]);
    end else begin
      fail_tests++;
      $display("Test %0d: FAILED", v_num[idx]);
    end
  endtask

  initial begin
    arst_n_i   = 1'b0;
    tx_req_i   = 1'b0;
    tx_dst_i   = '0;
    tx_class_i = DMA;
    tx_len_i   = '0;
    tx_tag_i   = '0;
    tx_seed_i  = '0;
    rx_stall_i = 1'b0;
    rnd        = $urandom(50);
    read_vectors();
    if (num_vecs == 0) begin
      $display("No vectors were read, so nothing was tested.");
      error_count++;
    end
    limit_cycles = RESET_CYCLES + DRAIN_CYCLES;
    for (int i = 0; i < num_vecs; i++) limit_cycles += int'(v_len[i]) + 16 + 8;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    if (tx_busy_o !== 1'b0) flag_mismatch("tx_busy_o", 1'b0, tx_busy_o);
    if (rx_valid_o !== 1'b0) flag_mismatch("rx_valid_o", 1'b0, rx_valid_o);
    if (rx_drop_o !== 1'b0) flag_mismatch("rx_drop_o", 1'b0, rx_drop_o);
    arst_n_i = 1'b1;
    for (int i = 0; i < num_vecs; i++) run_test(i);
    repeat (DRAIN_CYCLES) @(negedge clk);
    if (report_count != num_vecs) begin
      $display("%0d reports were seen for %0d commands.", report_count, num_vecs);
      error_count++;
    end
    $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
             num_vecs, pass_tests, fail_tests, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/noc_tile_link_vectors.txt */
// test dst class len tag seed stall_mask sum drop, one packet per line, all hex.
// Bit k of stall_mask holds the sink in cycle k after the command; sum is the payload XOR.
01 2 0 01 A001 12345678 0000 00000000 0
02 2 1 02 A002 00000100 0000 00000100 0
03 2 2 04 A003 DEAD0010 0000 DEAD0013 0
// Sink held for 16 cycles, longer than the FIFO depth.
04 2 3 0A A004 CAFE0000 FFFF CAFE0008 0
// Longest packet with a stall in the middle.
05 2 0 1F A005 00001000 00F0 00000001 0
// Wrong destination, then a normal packet.
06 3 3 06 A006 55AA0000 0000 55AA0004 1
07 2 0 03 A007 80000001 0000 00000003 0
// Header-only packet to another tile.
08 0 1 01 A008 00000000 0000 00000000 1
// Payload words wrap past the top of the 32-bit range.
09 2 2 07 A009 FFFFFFFE 0000 00000001 0
0A 2 3 08 A00A 0000FF00 5555 0000FF07 0
0B 2 1 10 A00B 00000020 0FFF 0000002F 0
0C 2 0 02 A00C 13579BDF 0003 13579BDF 0
